/* include/pip_defs.svh */
`ifndef PIP_DEFS_SVH
`define PIP_DEFS_SVH

// memory depths in 32-bit words
`define PIP_IMEM_DEPTH 64
`define PIP_DMEM_DEPTH 16

// host address map
`define PIP_HOST_AW 8
`define PIP_HOST_IMEM_BASE 8'h00
`define PIP_HOST_REG_BASE 8'h40
`define PIP_HOST_CTRL 8'h80

`endif

/* rtl/pip_types_pkg.sv */
`default_nettype none

package pip_types_pkg;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_FROM_EXMEM,
    FWD_FROM_MEMWB,
    FWD_FROM_MEMWB_LATE // store data picked up in MEM
  } fwd_t;

  typedef enum logic [3:0] {
    OP_PASS_A,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI
  } alu_op_t;

  typedef enum logic {
    RES_ALU,
    RES_SET
  } alu_res_t;

  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_r_t;

  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

/* rtl/pip_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

interface dec_if;
  import pip_types_pkg::*;

  logic        valid;
  logic [31:0] A;
  logic [31:0] B;
  logic [31:0] imm;
  logic        imm_valid;
  logic [4:0]  shamt;
  alu_op_t     alu_op;
  alu_res_t    alu_res_sel;
  logic        alu_set_u;
  fwd_t        A_fwd_from;
  fwd_t        B_fwd_from;
  logic        B_need_late;
  logic        alu_inst;
  logic        load_inst;
  logic        store_inst;
  logic [4:0]  dest_reg;
  logic        dest_reg_valid;

  modport master (output valid, A, B, imm, imm_valid, shamt, alu_op, alu_res_sel,
                  alu_set_u, A_fwd_from, B_fwd_from, B_need_late, alu_inst,
                  load_inst, store_inst, dest_reg, dest_reg_valid);
  modport slave (input valid, A, B, imm, imm_valid, shamt, alu_op, alu_res_sel,
                 alu_set_u, A_fwd_from, B_fwd_from, B_need_late, alu_inst,
                 load_inst, store_inst, dest_reg, dest_reg_valid);
endinterface

interface haz_if;
  logic [4:0] id_ex_dest_reg;
  logic       id_ex_dest_reg_valid;
  logic [4:0] ex_mem_dest_reg;
  logic       ex_mem_dest_reg_valid;
  logic       id_ex_load_inst;

  modport master (output id_ex_dest_reg, id_ex_dest_reg_valid, ex_mem_dest_reg,
                  ex_mem_dest_reg_valid, id_ex_load_inst);
  modport slave (input id_ex_dest_reg, id_ex_dest_reg_valid, ex_mem_dest_reg,
                 ex_mem_dest_reg_valid, id_ex_load_inst);
endinterface

interface wb_if;
  logic        we;
  logic [4:0]  waddr;
  logic [31:0] wdata;

  modport master (output we, waddr, wdata);
  modport slave (input we, waddr, wdata);
endinterface

`default_nettype wire

/* rtl/prog_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pip_defs.svh"

module prog_ctrl (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    host_req,
  input  logic                    host_we,
  input  logic [`PIP_HOST_AW-1:0] host_addr,
  input  logic [31:0]             host_wdata,
  output logic                    host_ack,
  output logic [31:0]             host_rdata,
  output logic                    busy,
  output pip_types_pkg::instr_u   inst,
  output logic                    inst_valid,
  input  logic                    stall,
  input  logic                    pipe_empty,
  output logic [4:0]              host_raddr,
  input  logic [31:0]             rf_host_rdata
);

  logic [31:0] imem [`PIP_IMEM_DEPTH];
  logic [6:0]  pc;
  logic [6:0]  prog_len;
  logic        access;
  logic        sel_imem;
  logic        sel_reg;
  logic        sel_ctrl;
  logic        start;
  logic        fetch;
  logic        drained;

  assign access     = host_req && !host_ack; // first cycle of a request
  assign sel_imem   = (host_addr & 8'hc0) == `PIP_HOST_IMEM_BASE;
  assign sel_reg    = (host_addr & 8'he0) == `PIP_HOST_REG_BASE;
  assign sel_ctrl   = host_addr == `PIP_HOST_CTRL;
  assign host_raddr = host_addr[4:0];

  assign start   = access && host_we && sel_ctrl && !busy;
  assign fetch   = busy && pc < prog_len;
  assign drained = !fetch && !inst_valid && pipe_empty;

  always_ff @(posedge clock) begin
    if (rst) begin
      host_ack <= 1'b0;
      busy     <= 1'b0;
      prog_len <= 7'd0;
    end else begin
      if (access)
        host_ack <= 1'b1;
      else if (!host_req)
        host_ack <= 1'b0; // return to idle phase
      if (start) begin
        prog_len <= host_wdata[6:0];
        busy     <= 1'b1;
      end else if (busy && drained) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc         <= 7'd0;
      inst_valid <= 1'b0;
    end else if (start) begin
      pc <= 7'd0;
    end else if (!stall) begin
      inst_valid <= fetch;
      if (fetch)
        pc <= pc + 7'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch && !stall)
      inst <= imem[pc[5:0]];
    if (access && host_we && sel_imem && !busy)
      imem[host_addr[5:0]] <= host_wdata; // program load only while idle
    if (access) begin
      if (sel_reg)
        host_rdata <= rf_host_rdata;
      else if (sel_ctrl)
        host_rdata <= {31'd0, busy};
      else if (sel_imem)
        host_rdata <= imem[host_addr[5:0]];
      else
        host_rdata <= 32'd0;
    end
  end

endmodule

`default_nettype wire

/* rtl/idec.sv */
`timescale 1ns/1ns
`default_nettype none

module idec (
  input  logic                  clock,
  input  logic                  rst,
  input  pip_types_pkg::instr_u inst,
  input  logic                  inst_valid,
  output logic [4:0]            rd_addr1,
  output logic [4:0]            rd_addr2,
  input  logic [31:0]           rd_data1,
  input  logic [31:0]           rd_data2,
  haz_if.slave                  haz,
  dec_if.master                 dec,
  output logic                  stall
);
  import pip_types_pkg::*;

  logic       legal;
  logic       a_valid;
  logic       b_valid;
  logic       b_late;
  logic       fixed_shift;
  logic       imm_sext;
  logic       iformat;
  logic       is_alu;
  logic       is_load;
  logic       is_store;
  logic [4:0] dst;
  logic       dst_valid;
  alu_op_t    op;
  alu_res_t   res_sel;
  logic       set_u;
  logic       use_a;
  logic       use_b;
  logic       a_ex;
  logic       a_mem;
  logic       b_ex;
  logic       b_mem;
  logic       stalled_q;
  logic       bubble;

  assign rd_addr1 = inst.i.rs;
  assign rd_addr2 = inst.i.rt;

  always_comb begin
    legal       = 1'b1;
    a_valid     = 1'b1;
    b_valid     = 1'b0;
    b_late      = 1'b0;
    fixed_shift = 1'b0;
    imm_sext    = 1'b0;
    iformat     = 1'b1;
    is_alu      = 1'b1;
    is_load     = 1'b0;
    is_store    = 1'b0;
    dst         = inst.i.rt;
    dst_valid   = 1'b1;
    op          = OP_PASS_A;
    res_sel     = RES_ALU;
    set_u       = 1'b0;

    case (inst.i.opc)
      6'h00: begin
        iformat     = 1'b0;
        dst         = inst.r.rd;
        b_valid     = 1'b1;
        fixed_shift = inst.r.funct[5:2] == 4'd0; // sll, srl, sra
        a_valid     = !fixed_shift;
        case (inst.r.funct)
          6'd0, 6'd4:   op = OP_SLL;
          6'd2, 6'd6:   op = OP_SRL;
          6'd3, 6'd7:   op = OP_SRA;
          6'd32, 6'd33: op = OP_ADD;
          6'd34, 6'd35: op = OP_SUB;
          6'd36:        op = OP_AND;
          6'd37:        op = OP_OR;
          6'd38:        op = OP_XOR;
          6'd39:        op = OP_NOR;
          6'd42, 6'd43: begin // slt, sltu
            op      = OP_SUB;
            res_sel = RES_SET;
            set_u   = inst.r.funct[0];
          end
          default:      legal = 1'b0;
        endcase
      end
      6'h08, 6'h09: begin // addi, addiu
        op       = OP_ADD;
        imm_sext = 1'b1;
      end
      6'h0a, 6'h0b: begin // slti, sltiu
        op       = OP_SUB;
        res_sel  = RES_SET;
        set_u    = inst.i.opc[0];
        imm_sext = 1'b1;
      end
      6'h0c: op = OP_AND;
      6'h0d: op = OP_OR;
      6'h0e: op = OP_XOR;
      6'h0f: begin // lui
        op      = OP_LUI;
        a_valid = 1'b0;
      end
      6'h23: begin // lw
        op       = OP_ADD;
        imm_sext = 1'b1;
        is_alu   = 1'b0;
        is_load  = 1'b1;
      end
      6'h2b: begin // sw
        op        = OP_ADD;
        imm_sext  = 1'b1;
        is_alu    = 1'b0;
        is_store  = 1'b1;
        b_valid   = 1'b1;
        b_late    = 1'b1; // data only needed in MEM
        dst_valid = 1'b0;
      end
      default: legal = 1'b0;
    endcase
  end

  // hazard detection against EX and MEM
  assign use_a = inst_valid && legal && a_valid;
  assign use_b = inst_valid && legal && b_valid;
  assign a_ex  = use_a && haz.id_ex_dest_reg_valid && inst.i.rs == haz.id_ex_dest_reg;
  assign a_mem = use_a && haz.ex_mem_dest_reg_valid && inst.i.rs == haz.ex_mem_dest_reg;
  assign b_ex  = use_b && haz.id_ex_dest_reg_valid && inst.i.rt == haz.id_ex_dest_reg;
  assign b_mem = use_b && haz.ex_mem_dest_reg_valid && inst.i.rt == haz.ex_mem_dest_reg;

  // one bubble is enough, the load has reached MEM after it
  assign stall  = haz.id_ex_load_inst && (a_ex || (b_ex && !b_late)) && !stalled_q;
  assign bubble = stall || !inst_valid || !legal;

  always_ff @(posedge clock) begin
    if (rst)
      stalled_q <= 1'b0;
    else
      stalled_q <= stall;
  end

  assign dec.A_fwd_from = a_ex ? FWD_FROM_EXMEM : a_mem ? FWD_FROM_MEMWB : FWD_NONE;
  assign dec.B_fwd_from = b_ex ? (haz.id_ex_load_inst ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM)
                        : b_mem ? FWD_FROM_MEMWB : FWD_NONE;

  assign dec.valid          = !bubble;
  assign dec.A              = a_valid ? rd_data1 : 32'd0; // zero for lui and fixed shifts
  assign dec.B              = rd_data2;
  assign dec.imm            = imm_sext ? {{16{inst.i.imm[15]}}, inst.i.imm}
                                       : {16'd0, inst.i.imm};
  assign dec.imm_valid      = iformat;
  assign dec.shamt          = fixed_shift ? inst.r.shamt : 5'd0;
  assign dec.alu_op         = op;
  assign dec.alu_res_sel    = res_sel;
  assign dec.alu_set_u      = set_u;
  assign dec.B_need_late    = b_late;
  assign dec.alu_inst       = is_alu;
  assign dec.load_inst      = is_load && !bubble;
  assign dec.store_inst     = is_store && !bubble;
  assign dec.dest_reg       = dst;
  assign dec.dest_reg_valid = dst_valid && !bubble && dst != 5'd0;

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
  input  logic        clock,
  input  logic [4:0]  rd_addr1,
  input  logic [4:0]  rd_addr2,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2,
  wb_if.slave         wb,
  input  logic [4:0]  host_raddr,
  output logic [31:0] host_rdata
);

  logic [31:0] regs [32];

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0)
      return 32'd0;
    if (wb.we && wb.waddr == addr)
      return wb.wdata; // write-through
    return regs[addr];
  endfunction

  always_comb begin
    rd_data1   = read_port(rd_addr1);
    rd_data2   = read_port(rd_addr2);
    host_rdata = read_port(host_raddr);
  end

  always_ff @(posedge clock) begin
    if (wb.we)
      regs[wb.waddr] <= wb.wdata;
  end

endmodule

`default_nettype wire

/* rtl/exec_mem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pip_defs.svh"

module exec_mem (
  input  logic  clock,
  input  logic  rst,
  dec_if.slave  dec,
  haz_if.master haz,
  wb_if.master  wb,
  output logic  pipe_empty
);
  import pip_types_pkg::*;

  logic        ie_valid, ie_we, ie_load, ie_store, ie_imm_valid, ie_set_u, ie_late;
  logic [4:0]  ie_dest, ie_shamt;
  logic [31:0] ie_a, ie_b, ie_imm;
  alu_op_t     ie_op;
  alu_res_t    ie_res_sel;
  fwd_t        ie_a_fwd, ie_b_fwd;
  logic        em_valid, em_we, em_load, em_store, em_late;
  logic [4:0]  em_dest;
  logic [31:0] em_res, em_sdata;
  logic        mw_valid, mw_we;
  logic [4:0]  mw_dest;
  logic [31:0] mw_data;
  logic [31:0] dmem [`PIP_DMEM_DEPTH];
  logic [31:0] a, b, b_op, alu_out, res, ld_data, st_data;
  logic [32:0] diff;
  logic        lt;

  always_ff @(posedge clock) begin
    if (rst) begin
      ie_valid <= 1'b0;
      ie_we    <= 1'b0;
      ie_load  <= 1'b0;
      ie_store <= 1'b0;
      em_valid <= 1'b0;
      em_we    <= 1'b0;
      em_load  <= 1'b0;
      em_store <= 1'b0;
      mw_valid <= 1'b0;
      mw_we    <= 1'b0;
    end else begin
      ie_valid <= dec.valid;
      ie_we    <= dec.dest_reg_valid && (dec.alu_inst || dec.load_inst);
      ie_load  <= dec.load_inst;
      ie_store <= dec.store_inst;
      em_valid <= ie_valid;
      em_we    <= ie_we;
      em_load  <= ie_load;
      em_store <= ie_store;
      mw_valid <= em_valid;
      mw_we    <= em_we;
    end
  end

  always_ff @(posedge clock) begin
    ie_a         <= dec.A;
    ie_b         <= dec.B;
    ie_imm       <= dec.imm;
    ie_imm_valid <= dec.imm_valid;
    ie_shamt     <= dec.shamt;
    ie_op        <= dec.alu_op;
    ie_res_sel   <= dec.alu_res_sel;
    ie_set_u     <= dec.alu_set_u;
    ie_a_fwd     <= dec.A_fwd_from;
    ie_b_fwd     <= dec.B_fwd_from;
    ie_late      <= dec.B_need_late && dec.B_fwd_from == FWD_FROM_MEMWB_LATE;
    ie_dest      <= dec.dest_reg;
    em_res       <= res;
    em_sdata     <= b;
    em_late      <= ie_late;
    em_dest      <= ie_dest;
    mw_data      <= em_load ? ld_data : em_res;
    mw_dest      <= em_dest;
  end

  always_comb begin
    case (ie_a_fwd)
      FWD_FROM_EXMEM: a = em_res;
      FWD_FROM_MEMWB: a = mw_data;
      default:        a = ie_a;
    endcase
    case (ie_b_fwd)
      FWD_FROM_EXMEM: b = em_res;
      FWD_FROM_MEMWB: b = mw_data;
      default:        b = ie_b; // late case is resolved in MEM
    endcase
  end

  assign b_op = ie_imm_valid ? ie_imm : b;
  assign diff = {1'b0, a} - {1'b0, b_op};
  assign lt   = ie_set_u ? diff[32] : ((a[31] ^ b_op[31]) ? a[31] : diff[31]);

  // fixed shifts arrive with A zero, variable ones with shamt zero
  always_comb begin
    case (ie_op)
      OP_ADD:  alu_out = a + b_op;
      OP_SUB:  alu_out = diff[31:0];
      OP_AND:  alu_out = a & b_op;
      OP_OR:   alu_out = a | b_op;
      OP_XOR:  alu_out = a ^ b_op;
      OP_NOR:  alu_out = ~(a | b_op);
      OP_SLL:  alu_out = b_op << (ie_shamt | a[4:0]);
      OP_SRL:  alu_out = b_op >> (ie_shamt | a[4:0]);
      OP_SRA:  alu_out = $signed(b_op) >>> (ie_shamt | a[4:0]);
      OP_LUI:  alu_out = {b_op[15:0], 16'd0};
      default: alu_out = a;
    endcase
  end

  assign res = (ie_res_sel == RES_SET) ? {31'd0, lt} : alu_out;

  // word-only data memory
  assign ld_data = dmem[em_res[5:2]];
  assign st_data = em_late ? mw_data : em_sdata;

  always_ff @(posedge clock) begin
    if (em_store)
      dmem[em_res[5:2]] <= st_data;
  end

  assign haz.id_ex_dest_reg        = ie_dest;
  assign haz.id_ex_dest_reg_valid  = ie_we;
  assign haz.ex_mem_dest_reg       = em_dest;
  assign haz.ex_mem_dest_reg_valid = em_we;
  assign haz.id_ex_load_inst       = ie_load;

  assign wb.we    = mw_we;
  assign wb.waddr = mw_dest;
  assign wb.wdata = mw_data;

  assign pipe_empty = !(ie_valid || em_valid || mw_valid);

endmodule

`default_nettype wire

/* rtl/pip_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pip_defs.svh"

module pip_top (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    host_req,
  input  logic                    host_we,
  input  logic [`PIP_HOST_AW-1:0] host_addr,
  input  logic [31:0]             host_wdata,
  output logic                    host_ack,
  output logic [31:0]             host_rdata,
  output logic                    busy
);
  import pip_types_pkg::*;

  instr_u      inst;
  logic        inst_valid;
  logic        stall;
  logic        pipe_empty;
  logic [4:0]  rd_addr1;
  logic [4:0]  rd_addr2;
  logic [4:0]  host_raddr;
  logic [31:0] rd_data1;
  logic [31:0] rd_data2;
  logic [31:0] rf_host_rdata;

  dec_if dec ();
  haz_if haz ();
  wb_if  wb ();

  prog_ctrl u_prog_ctrl (
    .clock, .rst,
    .host_req, .host_we, .host_addr, .host_wdata, .host_ack, .host_rdata,
    .busy, .inst, .inst_valid, .stall, .pipe_empty,
    .host_raddr, .rf_host_rdata
  );

  idec u_idec (
    .clock, .rst, .inst, .inst_valid,
    .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
    .haz(haz), .dec(dec), .stall
  );

  regfile u_regfile (
    .clock, .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
    .wb(wb), .host_raddr, .host_rdata(rf_host_rdata)
  );

  exec_mem u_exec_mem (
    .clock, .rst, .dec(dec), .haz(haz), .wb(wb), .pipe_empty
  );

endmodule

`default_nettype wire

/* verification/pip_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module pip_chk (
  input logic        clock,
  input logic        rst,
  input logic        host_req,
  input logic        host_ack,
  input logic [31:0] host_rdata,
  input logic        busy
);

  ack_needs_req: assert property (@(posedge clock) disable iff (rst)
    $rose(host_ack) |-> $past(host_req))
    else $error("host_ack rose without host_req");

  ack_held: assert property (@(posedge clock) disable iff (rst)
    host_ack && host_req |=> host_ack) // four-phase hold
    else $error("host_ack dropped while host_req was still high");

  rdata_stable: assert property (@(posedge clock) disable iff (rst)
    host_ack && $past(host_ack) |-> $stable(host_rdata))
    else $error("host_rdata changed while host_ack was high");

  reset_state: assert property (@(posedge clock)
    $fell(rst) |-> !busy && !host_ack)
    else $error("busy or host_ack high right after reset");

endmodule

bind pip_top pip_chk u_chk (
  .clock, .rst, .host_req, .host_ack, .host_rdata, .busy
);

`default_nettype wire

/* verification/pip_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "pip_defs.svh"

module pip_tb;

  localparam logic [5:0] R_FUNCTS [16] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd32, 6'd33,
                                           6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43};
  localparam logic [5:0] I_OPCS [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_ORI   = 6'h0d;
  localparam logic [5:0] OPC_LUI   = 6'h0f;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2b;
  localparam logic [5:0] FN_SLLV   = 6'd4;
  localparam logic [5:0] FN_ADDU   = 6'd33;
  localparam logic [5:0] FN_SUBU   = 6'd35;
  localparam logic [5:0] FN_OR     = 6'd37;
  localparam logic [5:0] FN_XOR    = 6'd38;

  logic                    clock;
  logic                    rst;
  logic                    host_req;
  logic                    host_we;
  logic [`PIP_HOST_AW-1:0] host_addr;
  logic [31:0]             host_wdata;
  logic                    host_ack;
  logic [31:0]             host_rdata;
  logic                    busy;

  logic [31:0] code_q [$];
  int          prog_start [$];
  int          prog_len [$];
  int          exp_prog [$];
  int          exp_reg [$];
  logic [31:0] exp_val [$];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mem [`PIP_DMEM_DEPTH];
  logic [31:0] got [32];
  integer      seed;
  int          cur_start;
  int          limit_cycles = 0;

  pip_top uut (
    .clock, .rst, .host_req, .host_we, .host_addr, .host_wdata, .host_ack, .host_rdata, .busy
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got_v,
                             input logic [31:0] exp_v);
    if (got_v !== exp_v)
      abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got_v, exp_v));
  endtask

  task automatic host_write(input logic [`PIP_HOST_AW-1:0] addr, input logic [31:0] data);
    @(negedge clock);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    do
      @(negedge clock);
    while (!host_ack);
    host_req = 1'b0;
    host_we  = 1'b0;
    do
      @(negedge clock);
    while (host_ack);
  endtask

  task automatic host_read(input logic [`PIP_HOST_AW-1:0] addr, output logic [31:0] data);
    @(negedge clock);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    do
      @(negedge clock);
    while (!host_ack);
    data     = host_rdata; // held until req falls
    host_req = 1'b0;
    do
      @(negedge clock);
    while (host_ack);
  endtask

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input int rd, input int rs,
                                        input int rt, input int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] opc, input int rt, input int rs,
                                        input logic [15:0] imm);
    return {opc, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic logic [31:0] random_alu();
    int          k;
    logic [31:0] r;
    k = {$random(seed)} % 24;
    r = $random(seed);
    if (k < 16)
      return enc_r(R_FUNCTS[k], r[4:0], r[9:5], r[14:10], r[19:15]);
    return enc_i(I_OPCS[k - 16], r[4:0], r[9:5], r[31:16]);
  endfunction

  // instruction set reference, one word at a time
  function automatic void ref_exec(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] val;
    logic [31:0] addr;
    logic [4:0]  sh;
    logic [4:0]  dst;
    logic        wr;
    a    = ref_regs[w[25:21]];
    b    = ref_regs[w[20:16]];
    se   = {{16{w[15]}}, w[15:0]};
    ze   = {16'd0, w[15:0]};
    addr = a + se;
    sh   = w[10:6];
    dst  = w[20:16];
    wr   = 1'b1;
    val  = 32'd0;
    case (w[31:26])
      6'h00: begin
        dst = w[15:11];
        case (w[5:0])
          6'd0:         val = b << sh;
          6'd2:         val = b >> sh;
          6'd3:         val = $signed(b) >>> sh;
          6'd4:         val = b << a[4:0];
          6'd6:         val = b >> a[4:0];
          6'd7:         val = $signed(b) >>> a[4:0];
          6'd32, 6'd33: val = a + b;
          6'd34, 6'd35: val = a - b;
          6'd36:        val = a & b;
          6'd37:        val = a | b;
          6'd38:        val = a ^ b;
          6'd39:        val = ~(a | b);
          6'd42:        val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          6'd43:        val = (a < b) ? 32'd1 : 32'd0;
          default:      wr = 1'b0;
        endcase
      end
      6'h08, 6'h09: val = a + se;
      6'h0a:        val = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      6'h0b:        val = (a < se) ? 32'd1 : 32'd0;
      6'h0c:        val = a & ze;
      6'h0d:        val = a | ze;
      6'h0e:        val = a ^ ze;
      6'h0f:        val = {w[15:0], 16'd0};
      6'h23:        val = ref_mem[addr[5:2]];
      6'h2b: begin
        ref_mem[addr[5:2]] = b;
        wr = 1'b0;
      end
      default:      wr = 1'b0;
    endcase
    if (wr && dst != 5'd0)
      ref_regs[dst] = val;
  endfunction

  function automatic void emit(input logic [31:0] w);
    code_q.push_back(w);
  endfunction

  function automatic void emit_padded(input logic [31:0] w, input int pad);
    emit(w);
    repeat (pad) emit(32'd0); // sll r0, r0, 0
  endfunction

  function automatic void expect_reg(input int r, input logic [31:0] v);
    exp_prog.push_back(prog_start.size());
    exp_reg.push_back(r);
    exp_val.push_back(v);
  endfunction

  function automatic void end_prog();
    prog_start.push_back(cur_start);
    prog_len.push_back(code_q.size() - cur_start);
    cur_start = code_q.size();
  endfunction

  function automatic void build_table();
    int k;
    int p;
    int pad;
    for (k = 1; k < 32; k++)
      emit(enc_i(OPC_ADDIU, k, 0, 16'(k * 257)));
    emit(enc_i(OPC_ADDIU, 0, 0, 16'h0077));
    emit(enc_r(FN_ADDU, 1, 0, 0, 0)); // reads r0 right after the write
    expect_reg(0, 32'd0);
    expect_reg(1, 32'd0);
    end_prog();
    // every ALU op on lui/ori operands
    emit(enc_i(OPC_LUI, 1, 0, 16'h8765));
    emit(enc_i(OPC_ORI, 1, 1, 16'h4321));
    emit(enc_i(OPC_LUI, 2, 0, 16'h1234));
    emit(enc_i(OPC_ORI, 2, 2, 16'h0009));
    for (k = 0; k < 16; k++)
      emit(enc_r(R_FUNCTS[k], 8 + k, 2, 1, 7));
    for (k = 0; k < 8; k++)
      emit(enc_i(I_OPCS[k], 24 + k, 1, 16'h8001));
    expect_reg(22, 32'd0); // slt, positive against negative
    expect_reg(23, 32'd1);
    end_prog();
    // same chain, tight then padded apart
    for (pad = 0; pad <= 3; pad += 3) begin
      emit_padded(enc_i(OPC_LUI, 3, 0, 16'h1234), pad);
      emit_padded(enc_i(OPC_ORI, 3, 3, 16'h5678), pad);
      emit_padded(enc_i(OPC_ADDIU, 6, 0, 16'd7), pad);
      emit_padded(enc_r(FN_ADDU, 4, 3, 3, 0), pad);
      emit_padded(enc_i(OPC_ADDIU, 7, 0, 16'hfff9), pad);
      emit_padded(enc_i(OPC_ADDIU, 8, 0, 16'd11), pad);
      emit_padded(enc_r(FN_SUBU, 5, 4, 8, 0), pad);
      emit_padded(enc_r(FN_XOR, 9, 7, 5, 0), pad);
      emit_padded(enc_r(FN_SLLV, 10, 6, 9, 0), pad);
      emit_padded(enc_r(FN_OR, 11, 9, 5, 0), pad);
      end_prog();
    end
    emit(enc_i(OPC_LUI, 12, 0, 16'hcafe));
    emit(enc_i(OPC_ORI, 12, 12, 16'hbeef));
    emit(enc_i(OPC_ADDIU, 13, 0, 16'd8));
    emit(enc_i(OPC_SW, 12, 13, 16'd4));
    emit(enc_i(OPC_LW, 14, 13, 16'd4));
    emit(enc_i(OPC_ADDIU, 15, 0, 16'h0100));
    emit(enc_i(OPC_SW, 15, 0, 16'd0));
    emit(enc_i(OPC_LW, 16, 0, 16'd0));
    emit(enc_r(FN_ADDU, 17, 16, 15, 0)); // load-use on A
    emit(enc_i(OPC_LW, 18, 0, 16'd12));
    emit(enc_i(OPC_SW, 18, 0, 16'd32)); // loaded word stored at once
    emit(enc_i(OPC_LW, 19, 0, 16'd32));
    emit(enc_i(OPC_LW, 20, 0, 16'd0));
    emit(enc_r(FN_ADDU, 21, 13, 20, 0)); // load-use on B
    expect_reg(14, 32'hcafebeef);
    expect_reg(17, 32'h00000200);
    expect_reg(19, 32'hcafebeef);
    expect_reg(21, 32'h00000108);
    end_prog();
    emit(enc_i(6'h3f, 5, 1, 16'h1234));
    emit(enc_i(6'h04, 6, 1, 16'h0002)); // beq
    emit(enc_i(6'h20, 7, 0, 16'h0000)); // lb
    emit(enc_r(6'h01, 8, 1, 2, 0));
    emit(enc_r(6'h18, 9, 1, 2, 0));     // mult
    emit(enc_r(6'h08, 10, 1, 0, 0));    // jr
    emit(enc_i(OPC_ADDIU, 11, 5, 16'd1));
    end_prog();
    for (p = 0; p < 20; p++) begin
      for (k = 0; k < 12; k++)
        emit(random_alu());
      end_prog();
    end
  endfunction

  task automatic run_program(input int p);
    int          i;
    int          r;
    logic [31:0] data;
    for (i = 0; i < prog_len[p]; i++) begin
      host_write(8'(`PIP_HOST_IMEM_BASE + i), code_q[prog_start[p] + i]);
      ref_exec(code_q[prog_start[p] + i]);
    end
    host_write(`PIP_HOST_CTRL, 32'(prog_len[p]));
    check_value($sformatf("busy after start, program %0d", p), busy, 32'd1);
    while (busy)
      @(negedge clock);
    for (r = 0; r < 32; r++) begin
      host_read(8'(`PIP_HOST_REG_BASE + r), data);
      got[r] = data;
      check_value($sformatf("host_rdata r%0d, program %0d", r, p), data, ref_regs[r]);
    end
    for (i = 0; i < exp_prog.size(); i++)
      if (exp_prog[i] == p)
        check_value($sformatf("host_rdata r%0d, program %0d", exp_reg[i], p),
                    got[exp_reg[i]], exp_val[i]);
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    abort_run($sformatf("timeout: run did not finish within %0d cycles", limit_cycles));
  end

  initial begin
    int          p;
    int          txns;
    logic [31:0] data;
    rst         = 1'b1;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = 32'd0;
    seed        = 94;
    cur_start   = 0;
    ref_regs[0] = 32'd0;
    build_table();
    txns = 2;
    for (p = 0; p < prog_start.size(); p++)
      txns += prog_len[p] + 33; // load, start, 32 reads
    limit_cycles = txns * 10 + 100 * prog_start.size();
    repeat (8) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    host_read(`PIP_HOST_REG_BASE, data);
    check_value("host_rdata r0 after reset", data, 32'd0);
    host_read(`PIP_HOST_CTRL, data);
    check_value("host_rdata busy after reset", data, 32'd0);
    for (p = 0; p < prog_start.size(); p++)
      run_program(p);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
rtl/pip_types_pkg.sv
rtl/pip_ifs.sv
rtl/prog_ctrl.sv
rtl/idec.sv
rtl/regfile.sv
rtl/exec_mem.sv
rtl/pip_top.sv
verification/pip_chk.sv
verification/pip_tb.sv

/* Bender.yml */
package:
  name: pip

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/pip_types_pkg.sv
      - rtl/pip_ifs.sv
      - rtl/prog_ctrl.sv
      - rtl/idec.sv
      - rtl/regfile.sv
      - rtl/exec_mem.sv
      - rtl/pip_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/pip_chk.sv
      - verification/pip_tb.sv
